//--- verification/exec_cases.txt
# instr pc regA regB bSrc oper invA invB cin sign immSrc aluJump brType expResult expNewPC
# all hex; brType 4 BEQZ, 5 BNEZ, 6 BLTZ, 7 BGEZ; oper 0 ROL .. 7 XOR
D800 0100 1234 0101 0 4 0 0 0 0 0 0 0 1335 0100
D800 0100 0005 0010 0 4 1 0 1 0 0 0 0 000B 0100
D800 0100 F0F0 3C3C 0 5 0 0 0 0 0 0 0 3030 0100
D800 0100 FFFF 1234 0 7 0 0 0 0 0 0 0 EDCB 0100
D804 0100 1234 0000 1 0 0 0 0 0 0 0 0 2341 0100
D81F 0100 0003 0000 1 1 0 0 0 0 0 0 0 8000 0100
D803 0100 1234 0000 2 2 0 0 0 0 0 0 0 8246 0100
D885 0100 8000 0000 2 3 0 0 0 0 0 0 0 0400 0100
D81E 0100 0010 0000 1 4 0 0 0 0 0 0 0 000E 0100
D8CD 0100 0000 12AB 3 6 0 0 0 0 0 0 0 ABCD 0100
E000 0100 0042 0042 0 4 0 1 1 1 0 0 0 0001 0100
E800 0100 FFFE 0003 0 4 0 1 1 1 0 0 0 0001 0100
E800 0100 7FFF 8000 0 4 0 1 1 1 0 0 0 0000 0100
F000 0100 0005 0005 0 4 0 1 1 1 0 0 0 0001 0100
F800 0100 FFFF 0001 0 4 0 0 0 0 0 0 0 0001 0100
C800 0100 1234 FFFF 0 4 0 0 0 0 0 0 0 2C48 0100
6010 0100 0000 00FF 0 4 0 0 0 0 0 0 4 0000 0110
6010 0100 0005 00FF 0 4 0 0 0 0 0 0 4 0005 0100
68F0 0100 0005 0000 0 4 0 0 0 0 0 0 5 0005 00F0
68F0 0100 0000 0000 0 4 0 0 0 0 0 0 5 0000 0100
7008 0100 8000 0000 0 4 0 0 0 0 0 0 6 8000 0108
7008 0100 0001 0000 0 4 0 0 0 0 0 0 6 0001 0100
7804 0100 0003 0000 0 4 0 0 0 0 0 0 7 0003 0104
7804 0100 FFFF 0000 0 4 0 0 0 0 0 0 7 FFFF 0100
2400 0800 0003 0000 0 4 0 0 0 0 1 0 0 0003 0400
3020 0200 0000 0000 0 4 0 0 0 0 1 0 0 0000 0220
2804 0100 1000 0000 1 4 0 0 0 0 0 1 0 1004 1004

//--- verilog.f
+incdir+source
source/execPkg.sv
source/alu.sv
source/creditCounter.sv
source/issueControl.sv
source/execute.sv
source/execTop.sv
verification/execTb.sv

//--- Makefile
# Verilator build and run for the execute stage testbench.
VERILATOR ?= verilator
TOP       ?= execTb
RTL_TOP   ?= execTop
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing -j $(JOBS)
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: run build lint clean

# Build, run, and pass only if the simulation printed the pass line.
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- verification/execTb.sv
/* Execute stage testbench with clock, reset, case file reader, upstream and
   write-back credit models, ordered result checks and cycle timeout. */
`timescale 1ns/10ps
`include "exec_defines.svh"

module execTb
   import execPkg::*;
;
   localparam int MaxCases = 64;
   localparam int Credits  = `EXEC_CREDITS;
   localparam int InBits   = 4*`EXEC_WIDTH + 14;    // Packed stimulus fields.

   logic clk, arstN, inValid, invA, invB, cin, sign, immSrc, aluJump, resCredit;
   instrWord_t             instr;
   logic [`EXEC_WIDTH-1:0] pc, regA, regB, result, newPC;
   logic [1:0]             bSrc;
   logic [2:0]             oper, brType;
   logic                   inCredit, outValid;
   logic [`EXEC_CNT_W-1:0] creditLevel;

   logic [InBits-1:0]        caseIn [MaxCases];  // Stimulus per case.
   logic [2*`EXEC_WIDTH-1:0] caseExp [MaxCases]; // {result, newPC}.
   logic [2*`EXEC_WIDTH-1:0] expQ [$];           // Issued, not yet seen.
   logic [2*`EXEC_WIDTH-1:0] expPair;
   int dueQ [$];                                 // Cycles when credits go back.
   int numCases, cycles, timeoutLimit, checked, received, returned, delay;
   int mismatches, others;
   logic upCredit, monitorOn, loadSeen, expectOut;
   logic [15:0] lfsr;

   execTop i_execTop (.*);

   always #5 clk = ~clk;                            // 10 ns period.

   ////////////////////////////////////////
   // Checks and random delays.
   ////////////////////////////////////////
   task automatic checkWord(input string name, input logic [`EXEC_WIDTH-1:0] got,
                            input logic [`EXEC_WIDTH-1:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic checkLevel(input logic [`EXEC_CNT_W-1:0] got,
                             input logic [`EXEC_CNT_W-1:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch at %0t: creditLevel got %0d expected %0d", $time, got, exp);
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois taps 16,14,13,11.
   endfunction

   task automatic drawDelay(output int d);
      d = 0;
      for (int b = 0; b < 3; b++) begin
         d    = (d << 1) | int'(lfsr[0]);          // One LFSR step per bit.
         lfsr = lfsrNext(lfsr);
      end
   endtask

   task automatic readCases();
      int fd, n;
      string line;
      logic [15:0] tInstr, tPc, tA, tB, tRes, tNpc;
      logic [1:0]  tBSrc;
      logic [2:0]  tOper, tBr;
      logic        tInvA, tInvB, tCin, tSign, tImm, tJmp;
      numCases = 0;
      fd = $fopen("verification/exec_cases.txt", "r");
      if (fd == 0) begin
         others++;
         $display("could not open the case file");
         return;
      end
      while ($fgets(line, fd)) begin
         if (line.len() < 2 || line.getc(0) == "#") continue;   // Comment or blank.
         n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     tInstr, tPc, tA, tB, tBSrc, tOper, tInvA, tInvB, tCin, tSign,
                     tImm, tJmp, tBr, tRes, tNpc);
         if (n != 15 || numCases >= MaxCases) begin
            others++;
            $display("case file line could not be used: %s", line);
            continue;
         end
         caseIn[numCases]  = {tInstr, tPc, tA, tB, tBSrc, tOper, tInvA, tInvB, tCin,
                              tSign, tImm, tJmp, tBr};
         caseExp[numCases] = {tRes, tNpc};
         numCases++;
      end
      $fclose(fd);
   endtask

   // Upstream model holds one credit and spends it on each inValid pulse.
   task automatic driveCases();
      int idx;
      idx = 0;
      while (idx < numCases) begin
         @(posedge clk);
         #1;
         inValid = 1'b0;
         if (upCredit) begin
            {instr, pc, regA, regB, bSrc, oper, invA, invB, cin, sign, immSrc,
             aluJump, brType} = caseIn[idx];
            inValid  = 1'b1;
            upCredit = 1'b0;
            expQ.push_back(caseExp[idx]);
            idx++;
         end
      end
      @(posedge clk);
      #1;
      inValid = 1'b0;
   endtask

   ////////////////////////////////////////
   // Monitor, write-back model, timeout.
   ////////////////////////////////////////
   always @(negedge clk) begin
      if (monitorOn) begin
         if (expectOut && !outValid) begin
            others++;
            $display("no result one cycle after an input that had a credit, at %0t", $time);
         end
         expectOut = 1'b0;
         if (outValid) begin
            received++;
            if (expQ.size() == 0) begin
               others++;
               $display("result at %0t with no case pending", $time);
            end else begin
               expPair = expQ.pop_front();
               checkWord($sformatf("result[%0d]", checked), result,
                         expPair[2*`EXEC_WIDTH-1:`EXEC_WIDTH]);
               checkWord($sformatf("newPC[%0d]", checked), newPC,
                         expPair[`EXEC_WIDTH-1:0]);
            end
            checked++;
            drawDelay(delay);
            dueQ.push_back(cycles + delay);
         end
         if (received - returned > Credits) begin
            others++;
            $display("more results outstanding than credits allow at %0t", $time);
         end
         checkLevel(creditLevel, `EXEC_CNT_W'(Credits - received + returned));
         if (resCredit) returned++;                 // Counts at the next edge.
         if (inCredit) upCredit = 1'b1;
         if (loadSeen && creditLevel != '0) expectOut = 1'b1;  // Issues now.
         loadSeen = inValid;
      end
   end

   always @(posedge clk) begin
      #1;
      resCredit = 1'b0;
      if (dueQ.size() > 0 && dueQ[0] <= cycles) begin
         resCredit = 1'b1;                          // One credit per cycle.
         void'(dueQ.pop_front());
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > timeoutLimit) begin
         $display("timeout: run stopped after %0d cycles", cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Main sequence.
   ////////////////////////////////////////
   initial begin
      clk = 1'b0;
      arstN = 1'b0;
      inValid = 1'b0;
      resCredit = 1'b0;
      {instr, pc, regA, regB, bSrc, oper, invA, invB, cin, sign, immSrc,
       aluJump, brType} = '0;
      {upCredit, monitorOn, loadSeen, expectOut} = '0;
      {cycles, checked, received, returned, mismatches, others} = '0;
      lfsr = 16'd50;
      timeoutLimit = 1000;
      readCases();
      timeoutLimit = numCases * 20 + 100;
      repeat (10) @(posedge clk);
      #1 arstN = 1'b1;
      @(negedge clk);
      checkFlag("outValid", outValid, 1'b0);        // Idle after reset.
      checkFlag("inCredit", inCredit, 1'b0);
      checkLevel(creditLevel, `EXEC_CNT_W'(Credits));
      monitorOn = 1'b1;
      upCredit  = 1'b1;
      driveCases();
      while (checked < numCases || returned < received) begin
         @(negedge clk);
      end
      repeat (4) @(posedge clk);
      $display("errors: %0d mismatches, %0d other failures", mismatches, others);
      if (mismatches == 0 && others == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- source/execTop.sv
/* Execute stage top: issue FSM, downstream credit counter and
   datapath wired together. */
`timescale 1ns/10ps
`include "exec_defines.svh"

module execTop
   import execPkg::*;
(
   input  logic                   clk,
   input  logic                   arstN,
   input  logic                   inValid,
   input  instrWord_t             instr,
   input  logic [`EXEC_WIDTH-1:0] pc,
   input  logic [`EXEC_WIDTH-1:0] regA,
   input  logic [`EXEC_WIDTH-1:0] regB,
   input  logic [1:0]             bSrc,
   input  logic [2:0]             oper,
   input  logic                   invA,
   input  logic                   invB,
   input  logic                   cin,
   input  logic                   sign,
   input  logic                   immSrc,
   input  logic                   aluJump,
   input  logic [2:0]             brType,
   input  logic                   resCredit,   // Credit back from write-back.
   output logic                   inCredit,    // Credit back to decode.
   output logic                   outValid,
   output logic [`EXEC_WIDTH-1:0] result,
   output logic [`EXEC_WIDTH-1:0] newPC,
   output logic [`EXEC_CNT_W-1:0] creditLevel
);

   logic load, fire, consume, avail;

   issueControl i_issueControl (
      .clk      (clk),
      .arstN    (arstN),
      .inValid  (inValid),
      .avail    (avail),
      .load     (load),
      .fire     (fire),
      .consume  (consume),
      .inCredit (inCredit)
   );

   creditCounter i_creditCounter (
      .clk     (clk),
      .arstN   (arstN),
      .consume (consume),
      .restore (resCredit),
      .avail   (avail),
      .level   (creditLevel)
   );

   execute i_execute (
      .clk      (clk),
      .arstN    (arstN),
      .load     (load),
      .fire     (fire),
      .instr    (instr),
      .pc       (pc),
      .regA     (regA),
      .regB     (regB),
      .bSrc     (bSrc),
      .oper     (oper),
      .invA     (invA),
      .invB     (invB),
      .cin      (cin),
      .sign     (sign),
      .immSrc   (immSrc),
      .aluJump  (aluJump),
      .brType   (brType),
      .result   (result),
      .newPC    (newPC),
      .outValid (outValid)
   );

endmodule

//--- source/execute.sv
/* Execute datapath with a one-entry input slot, B-operand select, ALU,
   compare and bit-reverse rewrite, branch test and output registers. */
`timescale 1ns/10ps
`include "exec_defines.svh"

module execute
   import execPkg::*;
(
   input  logic                   clk,
   input  logic                   arstN,
   input  logic                   load,      // Capture inputs into the slot.
   input  logic                   fire,      // Slot issues this cycle.
   input  instrWord_t             instr,
   input  logic [`EXEC_WIDTH-1:0] pc,        // Already incremented.
   input  logic [`EXEC_WIDTH-1:0] regA,
   input  logic [`EXEC_WIDTH-1:0] regB,
   input  logic [1:0]             bSrc,
   input  logic [2:0]             oper,
   input  logic                   invA,
   input  logic                   invB,
   input  logic                   cin,
   input  logic                   sign,
   input  logic                   immSrc,    // High picks disp11 for the target.
   input  logic                   aluJump,   // Next PC from the ALU.
   input  logic [2:0]             brType,
   output logic [`EXEC_WIDTH-1:0] result,
   output logic [`EXEC_WIDTH-1:0] newPC,
   output logic                   outValid
);

   localparam int W = `EXEC_WIDTH;

   ////////////////////////////////////////
   // Input slot.
   ////////////////////////////////////////
   instrWord_t   slotInstr;
   logic [W-1:0] slotPc, slotA, slotB;
   logic [1:0]   slotBSrc;
   logic [2:0]   slotOper, slotBrType;
   logic         slotInvA, slotInvB, slotCin, slotSign, slotImmSrc, slotAluJump;

   always_ff @(posedge clk) begin
      if (load) begin
         slotInstr   <= instr;
         slotPc      <= pc;
         slotA       <= regA;
         slotB       <= regB;
         slotBSrc    <= bSrc;
         slotOper    <= oper;
         slotInvA    <= invA;
         slotInvB    <= invB;
         slotCin     <= cin;
         slotSign    <= sign;
         slotImmSrc  <= immSrc;
         slotAluJump <= aluJump;
         slotBrType  <= brType;
      end
   end

   ////////////////////////////////////////
   // Operands and ALU.
   ////////////////////////////////////////
   logic [4:0]   opcode;
   logic [W-1:0] imm5, imm8, disp11, slbi, aluB, aluOut;
   logic         aluZero, aluOfl, aluSign;

   assign opcode = slotInstr.immForm.opcode;  // Same bits in all layouts.
   assign imm5   = {{(W-5){slotInstr.immForm.imm[4]}}, slotInstr.immForm.imm};
   assign imm8   = {{(W-8){slotInstr.brForm.imm[7]}}, slotInstr.brForm.imm};
   assign disp11 = {{(W-11){slotInstr.dispForm.disp[10]}}, slotInstr.dispForm.disp};
   // Low byte of rs moves up, the immediate byte fills in below.
   assign slbi   = {slotB[W-9:0], 8'h00} | {{(W-8){1'b0}}, slotInstr.brForm.imm};

   always_comb begin
      if (slotBrType[2] || (opcode == OP_BTR)) begin
         aluB = '0;                           // Branches test rs, BTR passes rs.
      end else begin
         case (slotBSrc)
            2'd0:    aluB = slotB;
            2'd1:    aluB = imm5;
            2'd2:    aluB = imm8;
            default: aluB = slbi;
         endcase
      end
   end

   alu i_alu (
      .inA  (slotA),
      .inB  (aluB),
      .cin  (slotCin),
      .invA (slotInvA),
      .invB (slotInvB),
      .sign (slotSign),
      .oper (slotOper),
      .out  (aluOut),
      .zero (aluZero),
      .ofl  (aluOfl)
   );

   assign aluSign = aluOut[W-1];

   ////////////////////////////////////////
   // Result rewrite and next PC.
   ////////////////////////////////////////
   logic [W-1:0] resNext, brTarget, pcNext;
   logic         condOk, taken;

   always_comb begin
      resNext = aluOut;
      case (opcode)
         OP_SEQ: resNext = {{(W-1){1'b0}}, aluZero};
         OP_SLT: resNext = {{(W-1){1'b0}}, aluOfl ? ~aluSign : aluSign};
         OP_SLE: resNext = {{(W-1){1'b0}}, aluOfl ? ~aluSign : (aluSign | aluZero)};
         OP_SCO: resNext = {{(W-1){1'b0}}, aluOfl};
         OP_BTR: begin
            for (int i = 0; i < W; i++) begin
               resNext[i] = aluOut[W-1-i];   // Mirror the word.
            end
         end
         default: resNext = aluOut;
      endcase
   end

   always_comb begin
      case (slotBrType)
         BR_NONE: condOk = 1'b0;
         BR_BEQZ: condOk = aluZero;
         BR_BNEZ: condOk = ~aluZero;
         BR_BLTZ: condOk = aluSign;
         BR_BGEZ: condOk = ~aluSign;        // Zero has a clear sign bit.
         default: condOk = 1'b0;            // Reserved codes never branch.
      endcase
   end

   assign taken    = ((opcode & OP_JMP_MASK) == OP_JMP_MATCH) | condOk;
   assign brTarget = slotPc + (slotImmSrc ? disp11 : imm8);
   assign pcNext   = slotAluJump ? aluOut : (taken ? brTarget : slotPc);

   ////////////////////////////////////////
   // Output registers.
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         outValid <= 1'b0;
      end else begin
         outValid <= fire;                  // One pulse per issued slot.
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         result <= resNext;
         newPC  <= pcNext;
      end
   end

endmodule

//--- source/issueControl.sv
/* Issue FSM: loads the input slot, issues it when a downstream
   credit exists, and hands the upstream credit back. */
`timescale 1ns/10ps

module issueControl (
   input  logic clk,
   input  logic arstN,
   input  logic inValid,   // Upstream spends its credit.
   input  logic avail,     // Downstream credit on hand.
   output logic load,      // Capture into the slot.
   output logic fire,      // Issue the slot.
   output logic consume,   // Spend a downstream credit.
   output logic inCredit   // Return the upstream credit.
);

   // State codes.
   localparam logic [1:0] Empty   = 2'd0;
   localparam logic [1:0] Ready   = 2'd1;
   localparam logic [1:0] Blocked = 2'd2;

   logic [1:0] state, stateNext;
   logic       issue;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state <= Empty;
      end else begin
         state <= stateNext;
      end
   end

   always_comb begin
      stateNext = state;
      load      = 1'b0;
      issue     = 1'b0;
      case (state)
         Empty: begin
            if (inValid) begin
               load      = 1'b1;
               stateNext = Ready;
            end
         end
         Ready: begin
            if (avail) begin
               issue     = 1'b1;
               stateNext = Empty;
            end else begin
               stateNext = Blocked;         // Wait for the consumer.
            end
         end
         Blocked: begin
            if (avail) begin
               issue     = 1'b1;
               stateNext = Empty;
            end
         end
         default: stateNext = Empty;
      endcase
   end

   // The three strobes always move together.
   assign fire     = issue;
   assign consume  = issue;
   assign inCredit = issue;

endmodule

//--- source/creditCounter.sv
/* Downstream credit counter, saturating at zero and full. */
`timescale 1ns/10ps
`include "exec_defines.svh"

module creditCounter (
   input  logic                  clk,
   input  logic                  arstN,
   input  logic                  consume,  // A result goes downstream.
   input  logic                  restore,  // Consumer hands a credit back.
   output logic                  avail,    // At least one credit left.
   output logic [`EXEC_CNT_W-1:0] level
);

   localparam logic [`EXEC_CNT_W-1:0] Full = `EXEC_CREDITS;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         level <= Full;                     // All credits at start.
      end else begin
         case ({consume, restore})
            2'b10: begin
               if (level != '0) begin
                  level <= level - 1'b1;
               end
            end
            2'b01: begin
               if (level != Full) begin
                  level <= level + 1'b1;
               end
            end
            default: level <= level;        // Idle, or both cancel out.
         endcase
      end
   end

   assign avail = (level != '0);

endmodule

//--- source/alu.sv
/* ALU with optional operand inversion, rotates, shifts, add and
   logic operations, plus zero and overflow flags. */
`timescale 1ns/10ps
`include "exec_defines.svh"

module alu
   import execPkg::*;
(
   input  logic [`EXEC_WIDTH-1:0] inA,    // Operand A.
   input  logic [`EXEC_WIDTH-1:0] inB,    // Operand B.
   input  logic                   cin,    // Carry into the adder.
   input  logic                   invA,   // Invert A first.
   input  logic                   invB,   // Invert B first.
   input  logic                   sign,   // Signed overflow when high.
   input  logic [2:0]             oper,   // Operation select.
   output logic [`EXEC_WIDTH-1:0] out,
   output logic                   zero,
   output logic                   ofl
);

   localparam int ShW = $clog2(`EXEC_WIDTH);  // 4 for a 16-bit word.
   localparam int Msb = `EXEC_WIDTH - 1;

   logic [`EXEC_WIDTH-1:0]   opA;       // A after optional inversion.
   logic [`EXEC_WIDTH-1:0]   opB;       // B after optional inversion.
   logic [`EXEC_WIDTH-1:0]   sum;       // Adder result.
   logic                     carry;     // Adder carry out.
   logic [ShW-1:0]           shAmt;     // Shift and rotate distance.
   logic [2*`EXEC_WIDTH-1:0] rolWide;   // Doubled word shifted left.
   logic [2*`EXEC_WIDTH-1:0] rorWide;   // Doubled word shifted right.

   assign opA   = invA ? ~inA : inA;
   assign opB   = invB ? ~inB : inB;
   assign shAmt = opB[ShW-1:0];         // Only the low bits count.

   assign {carry, sum} = opA + opB + cin;

   // Rotates come out of a word placed twice side by side.
   assign rolWide = {opA, opA} << shAmt;
   assign rorWide = {opA, opA} >> shAmt;

   always_comb begin
      case (oper)
         ALU_ROL: out = rolWide[2*`EXEC_WIDTH-1:`EXEC_WIDTH];  // Top half wraps in.
         ALU_SLL: out = opA << shAmt;
         ALU_ROR: out = rorWide[`EXEC_WIDTH-1:0];              // Bottom half wraps in.
         ALU_SRL: out = opA >> shAmt;                          // Logical, zero fill.
         ALU_ADD: out = sum;
         ALU_AND: out = opA & opB;
         ALU_OR:  out = opA | opB;
         ALU_XOR: out = opA ^ opB;
         default: out = sum;
      endcase
   end

   assign zero = (out == '0);

   // Signed: operands agree in sign and the sum does not.
   // Unsigned: carry out of the top bit.
   assign ofl = sign ? ((opA[Msb] == opB[Msb]) && (sum[Msb] != opA[Msb])) : carry;

endmodule

//--- source/execPkg.sv
/* Execute stage types and constants: the instruction word union,
   special opcodes, ALU operation codes and branch type codes. */
package execPkg;

   ////////////////////////////////////////
   // Instruction word, three field layouts.
   ////////////////////////////////////////
   typedef union packed {
      struct packed {
         logic [4:0] opcode;               // Same place in every layout.
         logic [2:0] rs;
         logic [2:0] rd;
         logic [4:0] imm;                  // Signed immediate for I-format.
      } immForm;
      struct packed {
         logic [4:0] opcode;
         logic [2:0] rs;
         logic [7:0] imm;                  // Branch offset or SLBI/LBI byte.
      } brForm;
      struct packed {
         logic [4:0]  opcode;
         logic [10:0] disp;                // Jump displacement.
      } dispForm;
   } instrWord_t;

   // Opcodes that need work after the ALU.
   localparam logic [4:0] OP_SEQ = 5'b11100;       // Set if equal.
   localparam logic [4:0] OP_SLT = 5'b11101;       // Set if less than.
   localparam logic [4:0] OP_SLE = 5'b11110;       // Set if less or equal.
   localparam logic [4:0] OP_SCO = 5'b11111;       // Set on carry out.
   localparam logic [4:0] OP_BTR = 5'b11001;       // Bit reverse.
   localparam logic [4:0] OP_JMP_MASK  = 5'b11101; // Bit 1 is don't care.
   localparam logic [4:0] OP_JMP_MATCH = 5'b00100; // J and JAL.

   // ALU operation select.
   localparam logic [2:0] ALU_ROL = 3'd0;
   localparam logic [2:0] ALU_SLL = 3'd1;
   localparam logic [2:0] ALU_ROR = 3'd2;
   localparam logic [2:0] ALU_SRL = 3'd3;
   localparam logic [2:0] ALU_ADD = 3'd4;
   localparam logic [2:0] ALU_AND = 3'd5;
   localparam logic [2:0] ALU_OR  = 3'd6;
   localparam logic [2:0] ALU_XOR = 3'd7;

   // Branch type, top bit set for a conditional branch.
   localparam logic [2:0] BR_NONE = 3'b000;
   localparam logic [2:0] BR_BEQZ = 3'b100;
   localparam logic [2:0] BR_BNEZ = 3'b101;
   localparam logic [2:0] BR_BLTZ = 3'b110;
   localparam logic [2:0] BR_BGEZ = 3'b111;

endpackage

//--- source/exec_defines.svh
/* Width and depth macros for the execute stage:
   data word width, downstream credit depth, credit count width. */
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Data path width of the teaching processor.
`define EXEC_WIDTH 16

// Results the write-back side can take before a credit returns.
`define EXEC_CREDITS 4

// Wide enough to hold EXEC_CREDITS itself.
`define EXEC_CNT_W 3

`endif
